// File: hdl/line_adapter_pkg.sv
`default_nettype none

package line_adapter_pkg;

    // byte address shared by the cache side and the memory side
    typedef logic [31:0] addr_t;

    // which transfer currently owns the memory port
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } burst_op_t;

    parameter int DEFAULT_BEAT_WIDTH = 64; // bits per memory beat
    parameter int DEFAULT_BEATS      = 4;  // beats per cache line

endpackage

`default_nettype wire

// File: hdl/burst_if.sv
`timescale 1ns/1ps
`default_nettype none

interface burst_if import line_adapter_pkg::*; #(
    parameter int BEAT_WIDTH = DEFAULT_BEAT_WIDTH,
    parameter int BEATS      = DEFAULT_BEATS
);
    logic                        start;      // one-cycle kick from the arbiter
    addr_t                       line_addr;  // aligned line address
    logic                        beat_valid;
    logic [BEAT_WIDTH-1:0]       beat_data;
    addr_t                       beat_addr;
    logic                        beat_ready; // write beat accepted by memory
    logic                        done;       // one-cycle completion from the engine
    logic [BEATS*BEAT_WIDTH-1:0] line_data;  // read result, or line to write
    logic                        wr_valid;
    logic [BEAT_WIDTH-1:0]       wr_data;

    modport rd_port (
        output start, line_addr, beat_valid, beat_data, beat_addr,
        input  done, line_data
    );
    modport rd_engine (
        input  start, line_addr, beat_valid, beat_data, beat_addr,
        output done, line_data
    );

    modport wr_port (
        output start, line_data, beat_ready,
        input  done, wr_valid, wr_data
    );
    modport wr_engine (
        input  start, line_data, beat_ready,
        output done, wr_valid, wr_data
    );

endinterface

`default_nettype wire

// File: hdl/line_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module line_deserializer import line_adapter_pkg::*; #(
    parameter int BEAT_WIDTH = DEFAULT_BEAT_WIDTH,
    parameter int BEATS      = DEFAULT_BEATS
) (
    input logic        clk,
    input logic        rst,
    burst_if.rd_engine bus
);
    localparam int               CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(BEATS - 1);

    logic [CNT_W-1:0]            count;  // next slot to fill
    logic                        active;
    logic                        done_q;
    addr_t                       addr_q; // line the beats must belong to
    logic [BEATS*BEAT_WIDTH-1:0] acc;
    logic                        take;

    // stale beats from another line are simply dropped
    assign take = active && bus.beat_valid && (bus.beat_addr == addr_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            count  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (bus.start) begin
                active <= 1'b1;
                count  <= '0;
            end else if (take) begin
                if (count == LAST) begin
                    active <= 1'b0;
                    count  <= '0;
                    done_q <= 1'b1; // line complete next cycle
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            addr_q <= bus.line_addr;
        end
        if (take) begin
            acc[count*BEAT_WIDTH +: BEAT_WIDTH] <= bus.beat_data; // lowest beat first
        end
    end

    assign bus.done      = done_q;
    assign bus.line_data = acc;

    // the arbiter only forwards beats while a read is in flight
    a_beat_inside_transfer: assert property (
        @(posedge clk) disable iff (rst)
        (bus.beat_valid && bus.beat_addr == addr_q) |-> active
    );

endmodule

`default_nettype wire

// File: hdl/line_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module line_serializer import line_adapter_pkg::*; #(
    parameter int BEAT_WIDTH = DEFAULT_BEAT_WIDTH,
    parameter int BEATS      = DEFAULT_BEATS
) (
    input logic        clk,
    input logic        rst,
    burst_if.wr_engine bus
);
    localparam int               CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(BEATS - 1);

    logic [CNT_W-1:0]            idx;      // beat currently on offer
    logic                        valid_q;
    logic                        done_q;
    logic [BEATS*BEAT_WIDTH-1:0] line_q;   // snapshot of the line at start
    logic                        accept;

    assign accept = valid_q && bus.beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            idx     <= '0;
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (bus.start) begin
                idx     <= '0;
                valid_q <= 1'b1; // beat zero goes out next cycle
            end else if (accept) begin
                if (idx == LAST) begin
                    valid_q <= 1'b0;
                    idx     <= '0;
                    done_q  <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            line_q <= bus.line_data;
        end
    end

    assign bus.wr_valid = valid_q;
    assign bus.wr_data  = line_q[idx*BEAT_WIDTH +: BEAT_WIDTH];
    assign bus.done     = done_q;

    // a stalled beat must hold until memory takes it
    a_wdata_hold: assert property (
        @(posedge clk) disable iff (rst)
        (valid_q && !bus.beat_ready) |=> (valid_q && $stable(bus.wr_data))
    );

endmodule

`default_nettype wire

// File: hdl/burst_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_port_arbiter import line_adapter_pkg::*; #(
    parameter int BEAT_WIDTH = DEFAULT_BEAT_WIDTH,
    parameter int BEATS      = DEFAULT_BEATS
) (
    input  logic                        clk,
    input  logic                        rst,

    input  addr_t                       dfp_addr,
    input  logic                        dfp_read,
    input  logic                        dfp_write,
    input  logic [BEATS*BEAT_WIDTH-1:0] dfp_wdata,
    output logic [BEATS*BEAT_WIDTH-1:0] dfp_rdata,
    output logic                        dfp_resp,

    output addr_t                       bmem_addr,
    output logic                        bmem_read,
    output logic                        bmem_write,
    output logic [BEAT_WIDTH-1:0]       bmem_wdata,
    input  logic                        bmem_ready,
    input  logic                        bmem_rvalid,
    input  addr_t                       bmem_raddr,
    input  logic [BEAT_WIDTH-1:0]       bmem_rdata,

    burst_if.rd_port                    rd,
    burst_if.wr_port                    wr
);
    localparam int OFFSET_W = $clog2(BEATS * BEAT_WIDTH / 8); // byte offset within a line

    burst_op_t owner;
    addr_t     line_addr_q;
    addr_t     aligned;
    logic      rd_start_q;
    logic      wr_start_q;

    assign aligned = (dfp_addr >> OFFSET_W) << OFFSET_W;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner      <= OP_IDLE;
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
            bmem_read  <= 1'b0;
            dfp_resp   <= 1'b0;
            dfp_rdata  <= '0;
        end else begin
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
            dfp_resp   <= rd.done | wr.done;
            if (rd.done) begin
                dfp_rdata <= rd.line_data;
            end
            // read command goes out the cycle after start, held until accepted
            if (rd_start_q) begin
                bmem_read <= 1'b1;
            end else if (bmem_ready) begin
                bmem_read <= 1'b0;
            end
            case (owner)
                OP_IDLE: begin
                    if (!dfp_resp && dfp_read) begin // resp cycle is skipped
                        owner      <= OP_READ;
                        rd_start_q <= 1'b1;
                    end else if (!dfp_resp && dfp_write) begin
                        owner      <= OP_WRITE;
                        wr_start_q <= 1'b1;
                    end
                end
                default: begin
                    if (rd.done || wr.done) begin
                        owner <= OP_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (owner == OP_IDLE) begin
            line_addr_q <= aligned;
        end
    end

    assign rd.start      = rd_start_q;
    assign rd.line_addr  = line_addr_q;
    assign rd.beat_valid = (owner == OP_READ) && bmem_rvalid;
    assign rd.beat_data  = bmem_rdata;
    assign rd.beat_addr  = bmem_raddr;

    assign wr.start      = wr_start_q;
    assign wr.line_data  = dfp_wdata; // cache holds it until dfp_resp
    assign wr.beat_ready = (owner == OP_WRITE) && bmem_ready;

    assign bmem_addr  = line_addr_q;
    assign bmem_write = (owner == OP_WRITE) && wr.wr_valid;
    assign bmem_wdata = wr.wr_data;

    a_one_request: assert property (@(posedge clk) disable iff (rst) !(dfp_read && dfp_write));
    a_one_done:    assert property (@(posedge clk) disable iff (rst) !(rd.done && wr.done));
    a_one_command: assert property (@(posedge clk) disable iff (rst) !(bmem_read && bmem_write));

endmodule

`default_nettype wire

// File: hdl/line_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module line_adapter import line_adapter_pkg::*; #(
    parameter int BEAT_WIDTH = DEFAULT_BEAT_WIDTH,
    parameter int BEATS      = DEFAULT_BEATS
) (
    input  logic                        clk,
    input  logic                        rst,

    input  addr_t                       dfp_addr,
    input  logic                        dfp_read,
    input  logic                        dfp_write,
    input  logic [BEATS*BEAT_WIDTH-1:0] dfp_wdata,
    output logic [BEATS*BEAT_WIDTH-1:0] dfp_rdata,
    output logic                        dfp_resp,

    output addr_t                       bmem_addr,
    output logic                        bmem_read,
    output logic                        bmem_write,
    output logic [BEAT_WIDTH-1:0]       bmem_wdata,
    input  logic                        bmem_ready,
    input  logic                        bmem_rvalid,
    input  addr_t                       bmem_raddr,
    input  logic [BEAT_WIDTH-1:0]       bmem_rdata
);

    burst_if #(.BEAT_WIDTH(BEAT_WIDTH), .BEATS(BEATS)) rd_bus ();
    burst_if #(.BEAT_WIDTH(BEAT_WIDTH), .BEATS(BEATS)) wr_bus ();

    line_deserializer #(.BEAT_WIDTH(BEAT_WIDTH), .BEATS(BEATS)) u_deserializer (
        .clk (clk),
        .rst (rst),
        .bus (rd_bus)
    );

    line_serializer #(.BEAT_WIDTH(BEAT_WIDTH), .BEATS(BEATS)) u_serializer (
        .clk (clk),
        .rst (rst),
        .bus (wr_bus)
    );

    burst_port_arbiter #(.BEAT_WIDTH(BEAT_WIDTH), .BEATS(BEATS)) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .dfp_addr    (dfp_addr),
        .dfp_read    (dfp_read),
        .dfp_write   (dfp_write),
        .dfp_wdata   (dfp_wdata),
        .dfp_rdata   (dfp_rdata),
        .dfp_resp    (dfp_resp),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_wdata  (bmem_wdata),
        .bmem_ready  (bmem_ready),
        .bmem_rvalid (bmem_rvalid),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .rd          (rd_bus),
        .wr          (wr_bus)
    );

endmodule

`default_nettype wire

// File: tb/tb_line_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_line_adapter import line_adapter_pkg::*; ();
    localparam int BEAT_WIDTH   = DEFAULT_BEAT_WIDTH;
    localparam int BEATS        = DEFAULT_BEATS;
    localparam int LINE_W       = BEATS * BEAT_WIDTH;
    localparam int BEAT_BYTES   = BEAT_WIDTH / 8;
    localparam int LINE_BYTES   = LINE_W / 8;
    localparam int MEM_DEPTH    = 1024; // beats held by the memory model
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;

    logic clk = 1'b0;
    logic rst = 1'b1;
    addr_t dfp_addr = '0;
    logic dfp_read = 1'b0;
    logic dfp_write = 1'b0;
    logic [LINE_W-1:0] dfp_wdata = '0;
    logic [LINE_W-1:0] dfp_rdata;
    logic dfp_resp;
    addr_t bmem_addr;
    logic bmem_read, bmem_write;
    logic [BEAT_WIDTH-1:0] bmem_wdata;
    logic bmem_ready = 1'b1;
    logic bmem_rvalid = 1'b0;
    addr_t bmem_raddr = '0;
    logic [BEAT_WIDTH-1:0] bmem_rdata = '0;

    logic [BEAT_WIDTH-1:0] mem [MEM_DEPTH];
    logic rd_pending = 1'b0;
    addr_t rd_line = '0;
    int rd_idx = 0;
    int wr_idx = 0;
    int write_beats = 0;
    int beats_at_resp = 0;
    logic hold_pending = 1'b0;
    logic [BEAT_WIDTH-1:0] hold_data = '0;
    addr_t expected_line = '0;
    logic ready_random = 1'b0;
    logic gap_random = 1'b0;
    logic stale_beat = 1'b0;
    integer seed = 99;

    line_adapter #(.BEAT_WIDTH(BEAT_WIDTH), .BEATS(BEATS)) u_line_adapter (
        .clk(clk), .rst(rst),
        .dfp_addr(dfp_addr), .dfp_read(dfp_read), .dfp_write(dfp_write),
        .dfp_wdata(dfp_wdata), .dfp_rdata(dfp_rdata), .dfp_resp(dfp_resp),
        .bmem_addr(bmem_addr), .bmem_read(bmem_read), .bmem_write(bmem_write),
        .bmem_wdata(bmem_wdata), .bmem_ready(bmem_ready), .bmem_rvalid(bmem_rvalid),
        .bmem_raddr(bmem_raddr), .bmem_rdata(bmem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic value_error(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic protocol_error(input string what);
        $display("error: %s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic int beat_index(input addr_t a);
        return (a / BEAT_BYTES) % MEM_DEPTH;
    endfunction

    function automatic logic [LINE_W-1:0] model_line(input addr_t line);
        logic [LINE_W-1:0] l;
        for (int i = 0; i < BEATS; i++) begin
            l[i*BEAT_WIDTH +: BEAT_WIDTH] = mem[beat_index(line + i * BEAT_BYTES)]; // lowest first
        end
        return l;
    endfunction

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] l;
        for (int i = 0; i < LINE_W / 32; i++) begin
            l[i*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    // memory model samples handshakes at the falling edge and answers after the rising edge
    always begin
        @(negedge clk);
        if (!rst) begin
            assert (!(bmem_read && bmem_write))
                else protocol_error("bmem_read and bmem_write were high together");
            if (hold_pending) begin
                assert (bmem_write) else protocol_error("bmem_write dropped before acceptance");
                assert (bmem_wdata == hold_data)
                    else value_error("bmem_wdata", bmem_wdata, hold_data);
            end
            hold_pending = bmem_write && !bmem_ready;
            hold_data    = bmem_wdata;
            if (dfp_resp) begin
                beats_at_resp = write_beats; // accepts before this cycle only
            end
            if (bmem_write && bmem_ready) begin
                assert (bmem_addr == expected_line)
                    else value_error("bmem_addr", bmem_addr, expected_line);
                mem[beat_index(bmem_addr + wr_idx * BEAT_BYTES)] = bmem_wdata;
                wr_idx      = (wr_idx + 1) % BEATS;
                write_beats = write_beats + 1;
            end
            if (bmem_read && bmem_ready) begin
                assert (bmem_addr == expected_line)
                    else value_error("bmem_addr", bmem_addr, expected_line);
                rd_pending = 1'b1;
                rd_line    = bmem_addr;
                rd_idx     = 0;
            end
        end
        @(posedge clk);
        #2;
        bmem_ready  = ready_random ? (($random(seed) & 1) == 1) : 1'b1;
        bmem_rvalid = 1'b0;
        if (rd_pending) begin
            if (stale_beat && rd_idx == 1) begin
                bmem_rvalid = 1'b1;
                bmem_raddr  = rd_line ^ addr_t'(LINE_BYTES); // beat of a neighbouring line
                bmem_rdata  = '1;
                stale_beat  = 1'b0;
            end else if (!gap_random || ($random(seed) & 1) == 1) begin
                bmem_rvalid = 1'b1;
                bmem_raddr  = rd_line;
                bmem_rdata  = mem[beat_index(rd_line + rd_idx * BEAT_BYTES)];
                rd_idx      = rd_idx + 1;
                rd_pending  = (rd_idx != BEATS);
            end
        end
    end

    // holds the request until dfp_resp and returns just after the next rising edge
    task automatic transfer(input logic is_write, input addr_t addr,
                            input logic [LINE_W-1:0] wdata, output logic [LINE_W-1:0] rdata);
        dfp_addr      = addr;
        dfp_read      = !is_write;
        dfp_write     = is_write;
        dfp_wdata     = wdata;
        expected_line = addr & ~addr_t'(LINE_BYTES - 1);
        @(negedge clk);
        assert (!dfp_resp) else protocol_error("dfp_resp was high for more than one cycle");
        while (!dfp_resp) @(negedge clk);
        rdata = dfp_rdata;
        @(posedge clk);
        #2;
    endtask

    task automatic release_request();
        dfp_read  = 1'b0;
        dfp_write = 1'b0;
        @(negedge clk);
        assert (!dfp_resp) else protocol_error("dfp_resp was high for more than one cycle");
        @(posedge clk);
        #2;
    endtask

    task automatic read_line(input addr_t addr, input logic [LINE_W-1:0] expected);
        logic [LINE_W-1:0] got;
        transfer(1'b0, addr, '0, got);
        assert (got == expected) else value_error("dfp_rdata", got, expected);
    endtask

    task automatic write_line(input addr_t addr, input logic [LINE_W-1:0] wdata);
        logic [LINE_W-1:0] unused;
        addr_t line;
        line        = addr & ~addr_t'(LINE_BYTES - 1);
        write_beats = 0;
        transfer(1'b1, addr, wdata, unused);
        assert (beats_at_resp == BEATS)
            else value_error("write beats before dfp_resp", beats_at_resp, BEATS);
        assert (model_line(line) == wdata) else value_error("memory line", model_line(line), wdata);
    endtask

    task automatic reset_state();
        repeat (4) begin
            @(negedge clk);
            assert (!dfp_resp) else value_error("dfp_resp", dfp_resp, 0);
            assert (!bmem_read) else value_error("bmem_read", bmem_read, 0);
            assert (!bmem_write) else value_error("bmem_write", bmem_write, 0);
            assert (dfp_rdata == '0) else value_error("dfp_rdata", dfp_rdata, 0);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic unaligned_read();
        read_line(32'h0000_0124, model_line(32'h0000_0120));
        release_request();
    endtask

    task automatic stale_beat_read();
        gap_random = 1'b1;
        stale_beat = 1'b1;
        read_line(32'h0000_0344, model_line(32'h0000_0340));
        release_request();
        gap_random = 1'b0;
        assert (!stale_beat) else protocol_error("the stale beat was never sent");
    endtask

    task automatic line_write();
        logic [LINE_W-1:0] data;
        data = random_line();
        write_line(32'h0000_0a08, data);
        release_request();
        read_line(32'h0000_0a00, data);
        release_request();
    endtask

    task automatic write_backpressure();
        ready_random = 1'b1;
        write_line(32'h0000_0c1f, random_line());
        release_request();
        ready_random = 1'b0;
        assert (write_beats == BEATS) else value_error("accepted write beats", write_beats, BEATS);
    endtask

    task automatic back_to_back();
        logic [LINE_W-1:0] data;
        data         = random_line();
        ready_random = 1'b1;
        gap_random   = 1'b1;
        write_line(32'h0000_1048, data);
        read_line(32'h0000_1040, data); // issued in the cycle after dfp_resp
        release_request();
        ready_random = 1'b0;
        gap_random   = 1'b0;
    endtask

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = BEAT_WIDTH'({32'(i * BEAT_BYTES), ~32'(i * BEAT_BYTES) ^ 32'h3c3c_a5a5});
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_state();
        unaligned_read();
        stale_beat_read();
        line_write();
        write_backpressure();
        back_to_back();
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #((NUM_TESTS * 200 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish in time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: line_adapter.f
hdl/line_adapter_pkg.sv
hdl/burst_if.sv
hdl/line_deserializer.sv
hdl/line_serializer.sv
hdl/burst_port_arbiter.sv
hdl/line_adapter.sv
tb/tb_line_adapter.sv
